// File: Makefile
VERILATOR ?= verilator
TOP       ?= secv_core_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
logic/secv_pkg.sv
logic/decoder.sv
logic/imm_gen.sv
logic/regfile.sv
logic/alu.sv
logic/pc_unit.sv
logic/secv_core.sv
sim/secv_core_checker.sv
sim/secv_core_tb.sv

// File: logic/alu.sv
// 64-bit ALU with 32-bit word operations and plain-add address mode
`timescale 1ns/1ns

module alu import secv_pkg::*; (
    input  xlen_t   a_i,       // Operand 1
    input  xlen_t   b_i,       // Operand 2
    input  funct3_t funct3_i,  // Operation
    input  funct7_t funct7_i,  // Bit 5 selects sub / arithmetic shift
    input  logic    alu_en_i,  // Plain add when low
    input  logic    word_i,    // 32-bit word op
    output xlen_t   res_o
);

    logic        alt;
    logic [5:0]  shamt;
    xlen_t       res_d;
    logic [31:0] res_w;

    assign alt   = funct7_i[5];
    assign shamt = b_i[5:0];

    // Doubleword path
    always_comb begin : dword_op
        res_d = a_i + b_i;  // Address and target computation
        if (alu_en_i) begin
            case (funct3_i)
                3'b000:  res_d = alt ? a_i - b_i : a_i + b_i;
                3'b001:  res_d = a_i << shamt;
                3'b010:  res_d = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
                3'b011:  res_d = {{(XLEN-1){1'b0}}, a_i < b_i};
                3'b100:  res_d = a_i ^ b_i;
                3'b101:  res_d = alt ? xlen_t'($signed(a_i) >>> shamt) : a_i >> shamt;
                3'b110:  res_d = a_i | b_i;
                default: res_d = a_i & b_i;
            endcase
        end
    end

    // Word path on the low 32 bits
    always_comb begin : word_op
        case (funct3_i)
            3'b001: begin
                res_w = a_i[31:0] << b_i[4:0];
            end
            3'b101: begin
                if (alt) begin
                    res_w = $signed(a_i[31:0]) >>> b_i[4:0];
                end else begin
                    res_w = a_i[31:0] >> b_i[4:0];
                end
            end
            default: begin
                res_w = alt ? a_i[31:0] - b_i[31:0] : a_i[31:0] + b_i[31:0];
            end
        endcase
    end

    assign res_o = (alu_en_i && word_i) ? {{32{res_w[31]}}, res_w} : res_d;

endmodule

// File: logic/decoder.sv
// Instruction decoder for register addresses, control selects and invalid-opcode error
`timescale 1ns/1ns

module decoder import secv_pkg::*; (
    input  inst_t   inst_i,     // Instruction word

    output regadr_t rs1_adr_o,  // Source register 1
    output regadr_t rs2_adr_o,  // Source register 2
    output regadr_t rd_adr_o,   // Destination register
    output ctrl_t   ctrl_o,     // Decoded control
    output logic    err_o       // Invalid opcode
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    ctrl_t   ctrl;
    logic    err;

    assign opcode = opcode_t'(inst_i.r_type.opcode);
    assign funct3 = inst_i.r_type.funct3;
    assign funct7 = inst_i.r_type.funct7;

    always_comb begin : decode_op
        // Safe defaults make no write and no memory access
        ctrl.funit    = FUNIT_NONE;
        ctrl.src1_sel = SRC1_SEL_0;
        ctrl.src2_sel = SRC2_SEL_0;
        ctrl.imm_sel  = IMM_SEL_0;
        ctrl.rd_sel   = RD_SEL_NONE;
        ctrl.pc_sel   = PC_SEL_NXTPC;
        ctrl.funct3   = funct3;
        ctrl.funct7   = funct7;
        ctrl.word     = 1'b0;
        ctrl.store    = 1'b0;
        err           = 1'b0;

        case (opcode)
            OPCODE_LUI: begin
                ctrl.imm_sel  = IMM_SEL_U;
                ctrl.rd_sel   = RD_SEL_IMM;
            end
            OPCODE_AUIPC: begin
                ctrl.funit    = FUNIT_ALU;
                ctrl.src1_sel = SRC1_SEL_PC;
                ctrl.src2_sel = SRC2_SEL_IMM;
                ctrl.imm_sel  = IMM_SEL_U;
                ctrl.rd_sel   = RD_SEL_FUNIT;
            end
            OPCODE_JAL, OPCODE_JALR: begin
                ctrl.funit    = FUNIT_ALU;
                ctrl.src1_sel = (opcode == OPCODE_JAL) ? SRC1_SEL_PC : SRC1_SEL_RS1;
                ctrl.src2_sel = SRC2_SEL_IMM;
                ctrl.imm_sel  = (opcode == OPCODE_JAL) ? IMM_SEL_J : IMM_SEL_I;
                ctrl.rd_sel   = RD_SEL_NXTPC;  // Link address
                ctrl.pc_sel   = PC_SEL_JUMP;
            end
            OPCODE_BRANCH: begin
                ctrl.funit    = FUNIT_ALU;     // Target = PC + imm
                ctrl.src1_sel = SRC1_SEL_PC;
                ctrl.src2_sel = SRC2_SEL_IMM;
                ctrl.imm_sel  = IMM_SEL_B;
                ctrl.pc_sel   = PC_SEL_BRANCH;
            end
            OPCODE_LOAD, OPCODE_STORE: begin
                ctrl.funit    = FUNIT_MEM;
                ctrl.src1_sel = SRC1_SEL_RS1;
                ctrl.src2_sel = SRC2_SEL_IMM;
                ctrl.store    = (opcode == OPCODE_STORE);
                ctrl.imm_sel  = ctrl.store ? IMM_SEL_S : IMM_SEL_I;
                ctrl.rd_sel   = ctrl.store ? RD_SEL_NONE : RD_SEL_FUNIT;
            end
            OPCODE_OP, OPCODE_OP_32: begin
                ctrl.funit    = FUNIT_ALU;
                ctrl.src1_sel = SRC1_SEL_RS1;
                ctrl.src2_sel = SRC2_SEL_RS2;
                ctrl.rd_sel   = RD_SEL_FUNIT;
                ctrl.word     = (opcode == OPCODE_OP_32);
            end
            OPCODE_OP_IMM, OPCODE_OP_IMM_32: begin
                ctrl.funit    = FUNIT_ALU;
                ctrl.src1_sel = SRC1_SEL_RS1;
                ctrl.src2_sel = SRC2_SEL_IMM;
                ctrl.imm_sel  = IMM_SEL_I;
                ctrl.rd_sel   = RD_SEL_FUNIT;
                ctrl.word     = (opcode == OPCODE_OP_IMM_32);
                // Bit 30 of the ADDI immediate never selects subtract
                if (funct3 == 3'b000) begin
                    ctrl.funct7 = '0;
                end
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

    assign rs1_adr_o = inst_i.r_type.rs1;
    assign rs2_adr_o = inst_i.r_type.rs2;
    assign rd_adr_o  = inst_i.r_type.rd;
    assign ctrl_o    = ctrl;
    assign err_o     = err;

endmodule

// File: logic/imm_gen.sv
// Immediate generator for the I, S, B, U and J instruction formats
`timescale 1ns/1ns

module imm_gen import secv_pkg::*; (
    input  inst_t    inst_i,     // Instruction word
    input  imm_sel_t imm_sel_i,  // Immediate format
    output xlen_t    imm_o       // Sign-extended immediate
);

    logic [31:0] i;
    xlen_t       imm;

    assign i = inst_i.raw;

    always_comb begin : build_imm
        case (imm_sel_i)
            IMM_SEL_I: imm = {{52{i[31]}}, i[31:20]};
            IMM_SEL_S: imm = {{52{i[31]}}, i[31:25], i[11:7]};
            // Branch offset with bit 0 implied zero
            IMM_SEL_B: imm = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            IMM_SEL_U: imm = {{32{i[31]}}, i[31:12], 12'b0};
            IMM_SEL_J: imm = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:   imm = '0;
        endcase
    end

    assign imm_o = imm;

endmodule

// File: logic/pc_unit.sv
// Program counter register, branch condition evaluation and next-PC selection
`timescale 1ns/1ns

module pc_unit import secv_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    step_i,      // Instruction completes this cycle
    input  pc_sel_t pc_sel_i,
    input  funct3_t funct3_i,    // Branch condition
    input  xlen_t   rs1_data_i,
    input  xlen_t   rs2_data_i,
    input  xlen_t   target_i,    // Jump/branch target from ALU
    output xlen_t   pc_o,
    output xlen_t   nxtpc_o      // PC + 4
);

    xlen_t pc_q;
    xlen_t pc_d;
    xlen_t nxtpc;
    xlen_t target;
    logic  taken;

    assign nxtpc  = pc_q + 64'd4;
    assign target = {target_i[XLEN-1:1], 1'b0};  // JALR clears bit 0

    always_comb begin : branch_cmp
        case (funct3_i)
            3'b000:  taken = (rs1_data_i == rs2_data_i);                   // BEQ
            3'b001:  taken = (rs1_data_i != rs2_data_i);                   // BNE
            3'b100:  taken = ($signed(rs1_data_i) <  $signed(rs2_data_i)); // BLT
            3'b101:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i)); // BGE
            3'b110:  taken = (rs1_data_i <  rs2_data_i);                   // BLTU
            3'b111:  taken = (rs1_data_i >= rs2_data_i);                   // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin : next_pc
        case (pc_sel_i)
            PC_SEL_JUMP:   pc_d = target;
            PC_SEL_BRANCH: pc_d = taken ? target : nxtpc;
            default:       pc_d = nxtpc;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (step_i) begin
            pc_q <= pc_d;
        end
    end

    assign pc_o    = pc_q;
    assign nxtpc_o = nxtpc;

endmodule

// File: logic/regfile.sv
// Integer register file with two combinational read ports and one write port
`timescale 1ns/1ns

module regfile import secv_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  regadr_t rs1_adr_i,
    input  regadr_t rs2_adr_i,
    input  regadr_t rd_adr_i,
    input  xlen_t   rd_data_i,
    input  logic    rd_we_i,
    output xlen_t   rs1_data_o,
    output xlen_t   rs2_data_o
);

    xlen_t regs [NREGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int n = 0; n < NREGS; n++) begin
                regs[n] <= '0;
            end
        end else if (rd_we_i && (rd_adr_i != '0)) begin  // x0 is hardwired
            regs[rd_adr_i] <= rd_data_i;
        end
    end

    // x0 reads zero
    assign rs1_data_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
    assign rs2_data_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];

endmodule

// File: logic/secv_core.sv
// Core top level with decoder, immediate generator, register file, ALU, PC unit and muxes
`timescale 1ns/1ns

module secv_core import secv_pkg::*; (
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  inst_valid_i,  // Execute inst_i this cycle
    input  inst_t inst_i,
    input  xlen_t mem_rdata_i,   // Combinational load data
    output xlen_t pc_o,
    output xlen_t mem_addr_o,
    output xlen_t mem_wdata_o,
    output logic  mem_re_o,
    output logic  mem_we_o,
    output wb_t   wb_o,
    output logic  err_o
);

    regadr_t rs1_adr;
    regadr_t rs2_adr;
    regadr_t rd_adr;
    ctrl_t   ctrl;
    logic    dec_err;
    logic    exec;
    logic    alu_en;
    xlen_t   imm;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    xlen_t   op_a;
    xlen_t   op_b;
    xlen_t   alu_res;
    xlen_t   nxtpc;
    wb_t     wb;

    assign exec = inst_valid_i & ~dec_err;

    decoder u_decoder (
        .inst_i    (inst_i),
        .rs1_adr_o (rs1_adr),
        .rs2_adr_o (rs2_adr),
        .rd_adr_o  (rd_adr),
        .ctrl_o    (ctrl),
        .err_o     (dec_err)
    );

    imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_sel_i (ctrl.imm_sel),
        .imm_o     (imm)
    );

    regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_adr_i  (rs1_adr),
        .rs2_adr_i  (rs2_adr),
        .rd_adr_i   (wb.rd),
        .rd_data_i  (wb.data),
        .rd_we_i    (wb.valid),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Operand muxes
    always_comb begin : operand_mux
        case (ctrl.src1_sel)
            SRC1_SEL_PC:  op_a = pc_o;
            SRC1_SEL_RS1: op_a = rs1_data;
            default:      op_a = '0;
        endcase
        case (ctrl.src2_sel)
            SRC2_SEL_RS2: op_b = rs2_data;
            SRC2_SEL_IMM: op_b = imm;
            default:      op_b = '0;
        endcase
    end

    // Full ALU operation for the OP and OP-IMM classes only
    assign alu_en = (ctrl.funit == FUNIT_ALU) && (ctrl.src1_sel == SRC1_SEL_RS1)
                 && (ctrl.rd_sel == RD_SEL_FUNIT);

    alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .funct3_i (ctrl.funct3),
        .funct7_i (ctrl.funct7),
        .alu_en_i (alu_en),
        .word_i   (ctrl.word),
        .res_o    (alu_res)
    );

    pc_unit u_pc_unit (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .step_i     (inst_valid_i),  // Invalid opcodes still advance
        .pc_sel_i   (ctrl.pc_sel),
        .funct3_i   (ctrl.funct3),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .target_i   (alu_res),
        .pc_o       (pc_o),
        .nxtpc_o    (nxtpc)
    );

    // Writeback mux
    always_comb begin : wb_mux
        wb.valid = exec && (ctrl.rd_sel != RD_SEL_NONE);
        wb.rd    = rd_adr;
        case (ctrl.rd_sel)
            RD_SEL_IMM:   wb.data = imm;
            RD_SEL_FUNIT: wb.data = (ctrl.funit == FUNIT_MEM) ? mem_rdata_i : alu_res;
            RD_SEL_NXTPC: wb.data = nxtpc;
            default:      wb.data = '0;
        endcase
    end

    // Doubleword memory port
    assign mem_addr_o  = alu_res;
    assign mem_wdata_o = rs2_data;
    assign mem_re_o    = exec && (ctrl.funit == FUNIT_MEM) && !ctrl.store;
    assign mem_we_o    = exec && (ctrl.funit == FUNIT_MEM) && ctrl.store;

    assign wb_o  = wb;
    assign err_o = inst_valid_i & dec_err;

endmodule

// File: logic/secv_pkg.sv
// Width constants, instruction word types, select enums and control/writeback structs
package secv_pkg;

    localparam int XLEN  = 64;
    localparam int NREGS = 32;

    // Basic types
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      regadr_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    localparam xlen_t RESET_PC = 64'h0000_0000_0000_1000;  // First fetch address

    // RV64I base opcodes used here
    typedef enum logic [6:0] {
        OPCODE_LUI       = 7'b0110111,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_OP        = 7'b0110011,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_OP_IMM_32 = 7'b0011011
    } opcode_t;

    // R-type field layout shared by rd, rs1 and funct3 of the other formats
    typedef struct packed {
        funct7_t    funct7;
        regadr_t    rs2;
        regadr_t    rs1;
        funct3_t    funct3;
        regadr_t    rd;
        logic [6:0] opcode;  // Raw bits that may hold an invalid code
    } r_type_t;

    typedef union packed {
        r_type_t     r_type;
        logic [31:0] raw;    // Flat view for immediate extraction
    } inst_t;

    // Datapath selects
    typedef enum logic [1:0] {
        FUNIT_NONE,
        FUNIT_ALU,
        FUNIT_MEM
    } funit_t;

    typedef enum logic [1:0] {
        SRC1_SEL_0,
        SRC1_SEL_PC,
        SRC1_SEL_RS1
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_SEL_0,
        SRC2_SEL_RS2,
        SRC2_SEL_IMM
    } src2_sel_t;

    typedef enum logic [2:0] {
        IMM_SEL_0,
        IMM_SEL_I,
        IMM_SEL_S,
        IMM_SEL_B,
        IMM_SEL_U,
        IMM_SEL_J
    } imm_sel_t;

    typedef enum logic [1:0] {
        RD_SEL_NONE,
        RD_SEL_IMM,
        RD_SEL_FUNIT,
        RD_SEL_NXTPC
    } rd_sel_t;

    typedef enum logic [1:0] {
        PC_SEL_NXTPC,
        PC_SEL_BRANCH,
        PC_SEL_JUMP
    } pc_sel_t;

    // Decoded control word
    typedef struct packed {
        funit_t    funit;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        imm_sel_t  imm_sel;
        rd_sel_t   rd_sel;
        pc_sel_t   pc_sel;
        funct3_t   funct3;
        funct7_t   funct7;
        logic      word;   // 32-bit op with sign-extended result
        logic      store;  // Memory write instead of read
    } ctrl_t;

    // Register writeback event
    typedef struct packed {
        logic    valid;
        regadr_t rd;
        xlen_t   data;
    } wb_t;

endpackage

// File: sim/secv_core_checker.sv
// Concurrent assertions on the memory port, writeback and idle outputs of secv_core
`timescale 1ns/1ns

module secv_core_checker import secv_pkg::*; (
    input logic clk_i,
    input logic arst_n_i,
    input logic inst_valid_i,
    input logic mem_re_i,
    input logic mem_we_i,
    input wb_t  wb_i,
    input logic err_i
);

    mem_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(mem_re_i && mem_we_i))
        else $error("memory read and write enabled in the same cycle");

    // Decode error blocks writeback
    wb_no_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(wb_i.valid && err_i))
        else $error("writeback valid together with decode error");

    idle_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !inst_valid_i |-> !(wb_i.valid || mem_re_i || mem_we_i || err_i))
        else $error("core output active without a valid instruction");

endmodule

bind secv_core secv_core_checker u_checker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .mem_re_i     (mem_re_o),
    .mem_we_i     (mem_we_o),
    .wb_i         (wb_o),
    .err_i        (err_o)
);

// File: sim/secv_core_tb.sv
// Testbench for secv_core with vector playback, a doubleword memory model and random idle cycles
`timescale 1ns/1ns

module secv_core_tb import secv_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NFIELD     = 10;  // Hex words per vector line
    localparam int MAXV       = 64;

    logic  clk_i;
    logic  arst_n_i;
    logic  inst_valid_i;
    inst_t inst_i;
    xlen_t mem_rdata_i;
    xlen_t pc_o;
    xlen_t mem_addr_o;
    xlen_t mem_wdata_o;
    logic  mem_re_o;
    logic  mem_we_o;
    wb_t   wb_o;
    logic  err_o;

    logic [63:0] vec [NFIELD*MAXV];
    xlen_t       mem_model [xlen_t];  // Sparse doubleword memory
    int          idle_n [MAXV];
    int          nvec;
    int          run_len;
    int          seed;

    secv_core dut0 (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .mem_rdata_i  (mem_rdata_i),
        .pc_o         (pc_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_re_o     (mem_re_o),
        .mem_we_o     (mem_we_o),
        .wb_o         (wb_o),
        .err_o        (err_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    function automatic xlen_t load_word(input xlen_t addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return ~addr;  // Fill for unwritten doublewords
    endfunction

    // Runs from 1 ns after one rising edge to 1 ns after the next
    task automatic run_vector(input int n);
        int    b;
        string tag;
        logic  exp_re;
        logic  st_we;
        xlen_t st_addr;
        xlen_t st_data;
        b   = n * NFIELD;
        tag = $sformatf("vec%0d", n);
        exp_re = vec[b][0] && (vec[b+1][6:0] == 7'b0000011);  // Valid LOAD major opcode
        inst_valid_i = vec[b][0];
        inst_i       = vec[b+1][31:0];
        #1;
        mem_rdata_i = mem_re_o ? load_word(mem_addr_o) : '0;  // Same-cycle read
        #3;
        check_val({tag, " wb_valid"}, vec[b+2], 64'(wb_o.valid));
        if (vec[b+2][0]) begin
            check_val({tag, " wb_rd"}, vec[b+3], 64'(wb_o.rd));
            check_val({tag, " wb_data"}, vec[b+4], wb_o.data);
        end
        check_val({tag, " mem_we"}, vec[b+6], 64'(mem_we_o));
        if (vec[b+6][0]) begin
            check_val({tag, " mem_addr"}, vec[b+7], mem_addr_o);
            check_val({tag, " mem_wdata"}, vec[b+8], mem_wdata_o);
        end
        check_val({tag, " err"}, vec[b+9], 64'(err_o));
        check_val({tag, " mem_re"}, 64'(exp_re), 64'(mem_re_o));
        st_we   = mem_we_o;
        st_addr = mem_addr_o;
        st_data = mem_wdata_o;
        @(posedge clk_i);
        if (st_we) begin
            mem_model[st_addr] = st_data;
        end
        #1;
        check_val({tag, " next_pc"}, vec[b+5], pc_o);
    endtask

    task automatic idle_cycle(input int n);
        xlen_t pc_hold;
        string tag;
        tag     = $sformatf("idle after vec%0d", n);
        pc_hold = pc_o;
        inst_valid_i = 1'b0;
        #4;
        check_val({tag, " wb_valid"}, 64'd0, 64'(wb_o.valid));
        check_val({tag, " mem_re"}, 64'd0, 64'(mem_re_o));
        check_val({tag, " mem_we"}, 64'd0, 64'(mem_we_o));
        check_val({tag, " err"}, 64'd0, 64'(err_o));
        @(posedge clk_i);
        #1;
        check_val({tag, " pc"}, pc_hold, pc_o);
    endtask

    initial begin : main
        int n;
        int nidle;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        mem_rdata_i  = '0;
        seed         = 32'h06b5_2c1b;
        nvec         = 0;
        nidle        = 0;
        run_len      = 0;
        for (n = 0; n < NFIELD*MAXV; n++) begin
            vec[n] = '1;  // Marks lines past the end of the file
        end
        $readmemh("sim/secv_vectors.txt", vec);
        while (nvec < MAXV && vec[nvec*NFIELD] != '1) begin
            nvec++;
        end
        if (nvec == 0) begin
            report_failure("No vectors could be read from sim/secv_vectors.txt");
        end
        for (n = 0; n < nvec; n++) begin
            idle_n[n] = int'($unsigned($random(seed)) % 3);
            nidle += idle_n[n];
        end
        run_len = nvec + nidle + 20;
        repeat (5) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_val("reset pc", RESET_PC, pc_o);
        for (n = 0; n < nvec; n++) begin
            run_vector(n);
            repeat (idle_n[n]) idle_cycle(n);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin : watchdog
        wait (run_len > 0);
        #(run_len * CLK_PERIOD);
        report_failure($sformatf("Timeout, run did not finish within %0d cycles", run_len));
    end

endmodule

// File: sim/secv_vectors.txt
// valid inst wb_valid wb_rd wb_data next_pc mem_we mem_addr mem_wdata err
// All fields hex, one instruction or idle slot per line, reset pc 1000
1 123450b7 1 01 12345000 1004 0 0 0 0 // lui x1, 0x12345
1 80000137 1 02 ffffffff80000000 1008 0 0 0 0 // lui x2, 0x80000
1 00001197 1 03 2008 100c 0 0 0 0 // auipc x3, 0x1
1 67808213 1 04 12345678 1010 0 0 0 0 // addi x4, x1, 0x678
1 fff00293 1 05 ffffffffffffffff 1014 0 0 0 0 // addi x5, x0, -1
1 00520333 1 06 12345677 1018 0 0 0 0 // add x6, x4, x5
1 401203b3 1 07 678 101c 0 0 0 0 // sub x7, x4, x1
1 0051043b 1 08 7fffffff 1020 0 0 0 0 // addw x8, x2, x5
1 4041549b 1 09 fffffffff8000000 1024 0 0 0 0 // sraiw x9, x2, 4
1 03c15513 1 0a f 1028 0 0 0 0 // srli x10, x2, 60
1 001125b3 1 0b 1 102c 0 0 0 0 // slt x11, x2, x1
1 fff24613 1 0c ffffffffedcba987 1030 0 0 0 0 // xori x12, x4, -1
1 00508013 1 00 12345005 1034 0 0 0 0 // addi x0, x1, 5
1 004006b3 1 0d 12345678 1038 0 0 0 0 // add x13, x0, x4
0 123450b7 0 00 0 1038 0 0 0 0 // idle slot
1 0041b823 0 00 0 103c 1 2018 12345678 0 // sd x4, 16(x3)
1 fe21bc23 0 00 0 1040 1 2000 ffffffff80000000 0 // sd x2, -8(x3)
1 0101b703 1 0e 12345678 1044 0 0 0 0 // ld x14, 16(x3)
1 ff81b783 1 0f ffffffff80000000 1048 0 0 0 0 // ld x15, -8(x3)
1 10003803 1 10 fffffffffffffeff 104c 0 0 0 0 // ld x16, 0x100(x0) unwritten
1 00c000ef 1 01 1050 1058 0 0 0 0 // jal x1, +12
1 021088e7 1 11 105c 1070 0 0 0 0 // jalr x17, 0x21(x1)
1 00e20863 0 00 0 1080 0 0 0 0 // beq x4, x14, +16 taken
1 00e21863 0 00 0 1084 0 0 0 0 // bne x4, x14, +16 not taken
1 00114463 0 00 0 108c 0 0 0 0 // blt x2, x1, +8 taken
1 00115463 0 00 0 1090 0 0 0 0 // bge x2, x1, +8 not taken
1 00116463 0 00 0 1094 0 0 0 0 // bltu x2, x1, +8 not taken
1 fe1178e3 0 00 0 1084 0 0 0 0 // bgeu x2, x1, -16 taken
1 00120463 0 00 0 1088 0 0 0 0 // beq x4, x1, +8 not taken
1 00121463 0 00 0 1090 0 0 0 0 // bne x4, x1, +8 taken
1 0020c463 0 00 0 1094 0 0 0 0 // blt x1, x2, +8 not taken
1 0020d463 0 00 0 109c 0 0 0 0 // bge x1, x2, +8 taken
1 0020e463 0 00 0 10a4 0 0 0 0 // bltu x1, x2, +8 taken
1 0020f463 0 00 0 10a8 0 0 0 0 // bgeu x1, x2, +8 not taken
1 ffffffff 0 00 0 10ac 0 0 0 1 // invalid opcode
0 ffffffff 0 00 0 10ac 0 0 0 0 // idle slot
1 00e88933 1 12 123466d4 10b0 0 0 0 0 // add x18, x17, x14
1 401009bb 1 13 ffffffffffffefb0 10b4 0 0 0 0 // subw x19, x0, x1
